// ==== hdl/ExecPkg.sv ====
`default_nettype none

package ExecPkg;

typedef logic [31:0] Word;
typedef logic [4:0] RegIdx;
typedef logic [6:0] SqN; // wraps, compare with isYounger only.

typedef enum logic [1:0] {
    FuAlu,
    FuMul,
    FuDiv
} FuType;

typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor,
    AluSll, AluSrl, AluSra, AluSlt, AluSltu
} AluOp;

typedef enum logic [1:0] {MulMul, MulMulh, MulMulhsu, MulMulhu} MulOp;

typedef enum logic [1:0] {DivDiv, DivDivu, DivRem, DivRemu} DivOp;

typedef struct packed {
    logic valid;
    FuType fu;
    logic [3:0] op; // cast to the unit's op enum.
    RegIdx srcA;
    RegIdx srcB;
    logic useImm;
    Word imm;
    RegIdx dst;
    SqN sqN;
} IssueUop;

typedef struct packed {
    logic valid;
    FuType fu;
    logic [3:0] op;
    Word a;
    Word b;
    RegIdx dst;
    SqN sqN;
    logic killed;
} ExecUop;

typedef struct packed {
    logic valid;
    logic killed;
    FuType fu;
    RegIdx dst;
    SqN sqN;
    Word result;
} ResultUop;

typedef struct packed {
    logic valid;
    SqN sqN;
} Flush;

typedef struct packed {
    logic valid;
    RegIdx dst;
    SqN sqN;
    Word result;
} WbOut;

localparam int AluLatency = 2; // operand read plus alu.

// a is younger than b.
function automatic logic isYounger(SqN a, SqN b);
    SqN diff;
    diff = a - b;
    return $signed(diff) > 0;
endfunction

function automatic logic flushHits(Flush f, SqN s);
    return f.valid && isYounger(s, f.sqN);
endfunction

endpackage

`default_nettype wire

// ==== hdl/IssueGate.sv ====
`default_nettype none

module IssueGate
#(
    parameter int MulStages = 3
)
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::IssueUop issue,
    input wire ExecPkg::ResultUop released,
    output logic ready
);

import ExecPkg::*;

// bit j set means the writeback slot j edges ahead is taken.
localparam int SlotBits = MulStages + 1;

logic [31:0] pending;
logic [31:0] nextPending;
logic [SlotBits:1] slotResv;
logic [SlotBits:1] nextSlot;
logic divToken;

logic accept;
logic srcBusy;
logic dstBusy;
logic slotBusy;
logic divBusy;

always_comb begin
    srcBusy = pending[issue.srcA] || (!issue.useImm && pending[issue.srcB]);
    dstBusy = pending[issue.dst];
    divBusy = (issue.fu == FuDiv) && divToken;
    slotBusy = 1'b0;
    if (issue.fu == FuAlu) slotBusy = slotResv[AluLatency];
    else if (issue.fu == FuMul) slotBusy = slotResv[SlotBits];
    ready = !(srcBusy || dstBusy || slotBusy || divBusy);
end

assign accept = issue.valid && ready;

always_comb begin
    nextPending = pending;
    if (released.valid && released.dst != '0)
        nextPending[released.dst] = 1'b0;
    if (accept && issue.dst != '0)
        nextPending[issue.dst] = 1'b1;
end

always_comb begin
    nextSlot = {1'b0, slotResv[SlotBits:2]};
    if (accept && issue.fu == FuAlu) nextSlot[AluLatency - 1] = 1'b1;
    if (accept && issue.fu == FuMul) nextSlot[SlotBits - 1] = 1'b1;
end

always_ff @(posedge clk) begin
    if (rst) begin
        pending <= '0;
        slotResv <= '0;
        divToken <= 1'b0;
    end
    else begin
        pending <= nextPending;
        slotResv <= nextSlot;
        if (accept && issue.fu == FuDiv)
            divToken <= 1'b1;
        else if (released.valid && released.fu == FuDiv)
            divToken <= 1'b0; // held until the divide leaves, even killed.
    end
end

releaseWasPending: assert property (@(posedge clk) disable iff (rst)
    released.valid && released.dst != '0 |-> pending[released.dst])
    else $error("release of r%0d without a pending entry", released.dst);

endmodule

`default_nettype wire

// ==== hdl/OperandFetch.sv ====
`default_nettype none

module OperandFetch
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::IssueUop issue,
    input wire accept,
    input wire ExecPkg::Flush flush,
    input wire ExecPkg::ResultUop regWrite,

    output ExecPkg::ExecUop exec
);

import ExecPkg::*;

Word regs[31:1]; // r0 is hardwired.
Word readA;
Word readB;

always_ff @(posedge clk) begin
    if (regWrite.valid && !regWrite.killed && regWrite.dst != '0)
        regs[regWrite.dst] <= regWrite.result;
end

assign readA = (issue.srcA == '0) ? '0 : regs[issue.srcA];
assign readB = (issue.srcB == '0) ? '0 : regs[issue.srcB];

always_ff @(posedge clk) begin
    if (accept) begin
        exec.fu <= issue.fu;
        exec.op <= issue.op;
        exec.a <= readA;
        exec.b <= issue.useImm ? issue.imm : readB;
        exec.dst <= issue.dst;
        exec.sqN <= issue.sqN;
    end
    if (rst) begin
        exec.valid <= 1'b0;
        exec.killed <= 1'b0;
    end
    else begin
        exec.valid <= accept;
        exec.killed <= accept && flushHits(flush, issue.sqN);
    end
end

endmodule

`default_nettype wire

// ==== hdl/IntAlu.sv ====
`default_nettype none

module IntAlu
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::ExecUop exec,
    input wire ExecPkg::Flush flush,

    output ExecPkg::ResultUop result
);

import ExecPkg::*;

logic capture;
logic [4:0] shamt;
Word value;

assign capture = exec.valid && exec.fu == FuAlu;
assign shamt = exec.b[4:0];

always_comb begin
    unique case (AluOp'(exec.op))
        AluAdd: value = exec.a + exec.b;
        AluSub: value = exec.a - exec.b;
        AluAnd: value = exec.a & exec.b;
        AluOr: value = exec.a | exec.b;
        AluXor: value = exec.a ^ exec.b;
        AluSll: value = exec.a << shamt;
        AluSrl: value = exec.a >> shamt;
        AluSra: value = $signed(exec.a) >>> shamt;
        AluSlt: value = Word'($signed(exec.a) < $signed(exec.b));
        AluSltu: value = Word'(exec.a < exec.b);
        default: value = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (capture) begin
        result.fu <= exec.fu;
        result.dst <= exec.dst;
        result.sqN <= exec.sqN;
        result.result <= value;
    end
    if (rst) begin
        result.valid <= 1'b0;
        result.killed <= 1'b0;
    end
    else begin
        result.valid <= capture;
        result.killed <= exec.killed || flushHits(flush, exec.sqN);
    end
end

endmodule

`default_nettype wire

// ==== hdl/Multiplier.sv ====
`default_nettype none

module Multiplier
#(
    parameter int MulStages = 3
)
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::ExecUop exec,
    input wire ExecPkg::Flush flush,

    output ExecPkg::ResultUop result
);

import ExecPkg::*;

ResultUop pipe[MulStages];
logic capture;
logic signA;
logic signB;
logic signed [32:0] opA;
logic signed [32:0] opB;
logic signed [65:0] product;
Word selected;

assign capture = exec.valid && exec.fu == FuMul;

always_comb begin
    case (MulOp'(exec.op[1:0]))
        MulMulhsu: begin
            signA = 1'b1;
            signB = 1'b0;
        end
        MulMulhu: begin
            signA = 1'b0;
            signB = 1'b0;
        end
        default: begin
            signA = 1'b1;
            signB = 1'b1;
        end
    endcase
    opA = {signA && exec.a[31], exec.a};
    opB = {signB && exec.b[31], exec.b};
    product = 66'(opA) * 66'(opB);
    selected = (MulOp'(exec.op[1:0]) == MulMul) ? product[31:0] : product[63:32];
end

always_ff @(posedge clk) begin
    if (capture) begin
        pipe[0].fu <= exec.fu;
        pipe[0].dst <= exec.dst;
        pipe[0].sqN <= exec.sqN;
        pipe[0].result <= selected;
    end
    for (int i = 1; i < MulStages; i++) begin
        pipe[i] <= pipe[i - 1];
        pipe[i].killed <= pipe[i - 1].killed || flushHits(flush, pipe[i - 1].sqN);
    end
    if (rst) begin
        for (int i = 0; i < MulStages; i++) begin
            pipe[i].valid <= 1'b0;
        end
    end
    else begin
        pipe[0].valid <= capture;
        pipe[0].killed <= exec.killed || flushHits(flush, exec.sqN);
    end
end

assign result = pipe[MulStages - 1];

endmodule

`default_nettype wire

// ==== hdl/Divider.sv ====
`default_nettype none

module Divider
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::ExecUop exec,
    input wire ExecPkg::Flush flush,
    input wire wbFree,

    output ExecPkg::ResultUop result
);

import ExecPkg::*;

typedef enum logic [1:0] {Idle, Run, Finish, Hold} DivState;

DivState state;
logic capture;
logic isSigned;
logic isRem;
logic negQ;
logic negR;
logic killed;
RegIdx dst;
SqN sqN;
Word divisor;
Word quo; // dividend shifts out as quotient shifts in.
Word rem;
Word value;
logic [4:0] count;
logic [33:0] trial;

assign capture = (state == Idle) && exec.valid && exec.fu == FuDiv;
assign isSigned = (DivOp'(exec.op[1:0]) == DivDiv) || (DivOp'(exec.op[1:0]) == DivRem);
assign trial = {1'b0, rem, quo[31]} - {2'b0, divisor};

always_ff @(posedge clk) begin
    if (capture) begin
        isRem <= exec.op[1];
        negQ <= isSigned && (exec.a[31] ^ exec.b[31]) && exec.b != '0; // /0 stays all ones.
        negR <= isSigned && exec.a[31];
        quo <= (isSigned && exec.a[31]) ? -exec.a : exec.a;
        divisor <= (isSigned && exec.b[31]) ? -exec.b : exec.b;
        rem <= '0;
        count <= 5'd31;
        dst <= exec.dst;
        sqN <= exec.sqN;
        killed <= exec.killed || flushHits(flush, exec.sqN);
    end
    else begin
        killed <= killed || flushHits(flush, sqN);
    end
    if (state == Run) begin
        if (!trial[33]) begin
            rem <= trial[31:0];
            quo <= {quo[30:0], 1'b1};
        end
        else begin
            rem <= {rem[30:0], quo[31]};
            quo <= {quo[30:0], 1'b0};
        end
        count <= count - 5'd1;
    end
    if (state == Finish)
        value <= isRem ? (negR ? -rem : rem) : (negQ ? -quo : quo);

    if (rst) state <= Idle;
    else begin
        unique case (state)
            Idle: if (capture) state <= Run;
            Run: if (count == '0) state <= Finish;
            Finish: state <= Hold;
            Hold: if (wbFree) state <= Idle; // waits out alu and mul results.
        endcase
    end
end

always_comb begin
    result.valid = (state == Hold) && wbFree;
    result.killed = killed;
    result.fu = FuDiv;
    result.dst = dst;
    result.sqN = sqN;
    result.result = value;
end

divOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
    exec.valid && exec.fu == FuDiv |-> state == Idle)
    else $error("div arrived while the divider was busy");

endmodule

`default_nettype wire

// ==== hdl/ExecCluster.sv ====
`default_nettype none

module ExecCluster
#(
    parameter int MulStages = 3
)
(
    input wire clk,
    input wire rst,

    input wire ExecPkg::IssueUop issue,
    input wire ExecPkg::Flush flush,
    output logic ready,

    output ExecPkg::WbOut wb
);

import ExecPkg::*;

logic accept;
assign accept = issue.valid && ready;

ExecUop execUop;
ResultUop aluRes;
ResultUop mulRes;
ResultUop divRes;
ResultUop wbSel;
logic wbFree;

IssueGate #(.MulStages(MulStages)) gate
(
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .released(wbSel),
    .ready(ready)
);

OperandFetch fetch
(
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .accept(accept),
    .flush(flush),
    .regWrite(wbSel),
    .exec(execUop)
);

IntAlu alu
(
    .clk(clk),
    .rst(rst),
    .exec(execUop),
    .flush(flush),
    .result(aluRes)
);

Multiplier #(.MulStages(MulStages)) mul
(
    .clk(clk),
    .rst(rst),
    .exec(execUop),
    .flush(flush),
    .result(mulRes)
);

// divider only gets the port when both fast units are quiet.
assign wbFree = !aluRes.valid && !mulRes.valid;

Divider divider
(
    .clk(clk),
    .rst(rst),
    .exec(execUop),
    .flush(flush),
    .wbFree(wbFree),
    .result(divRes)
);

always_comb begin
    if (aluRes.valid) wbSel = aluRes;
    else if (mulRes.valid) wbSel = mulRes;
    else wbSel = divRes;
end

always_comb begin
    wb.valid = wbSel.valid && !wbSel.killed; // killed ops only release.
    wb.dst = wbSel.dst;
    wb.sqN = wbSel.sqN;
    wb.result = wbSel.result;
end

aluMulNoCollide: assert property (@(posedge clk) disable iff (rst)
    !(aluRes.valid && mulRes.valid))
    else $error("alu and mul results collide on the writeback port");

endmodule

`default_nettype wire

// ==== sim/tbVectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH
`default_nettype none

localparam int NumRows = 32;

// fu, op, srcA, srcB, useImm, imm, dst, flushAfter, wbExp, expResult.
Row vectors[NumRows] = '{
    '{FuAlu, AluAdd, 5'd0, 5'd0, 1'b1, 32'h8000_0000, 5'd1, 1'b0, 1'b1, 32'h8000_0000},
    '{FuAlu, AluAdd, 5'd0, 5'd0, 1'b1, 32'h0000_0005, 5'd2, 1'b0, 1'b1, 32'h0000_0005},
    '{FuAlu, AluSub, 5'd2, 5'd1, 1'b0, 32'h0, 5'd3, 1'b0, 1'b1, 32'h8000_0005},
    '{FuAlu, AluSlt, 5'd1, 5'd2, 1'b0, 32'h0, 5'd4, 1'b0, 1'b1, 32'h0000_0001},
    '{FuAlu, AluSltu, 5'd1, 5'd2, 1'b0, 32'h0, 5'd5, 1'b0, 1'b1, 32'h0000_0000},
    '{FuAlu, AluSra, 5'd1, 5'd0, 1'b1, 32'h4, 5'd6, 1'b0, 1'b1, 32'hF800_0000},
    '{FuAlu, AluSrl, 5'd1, 5'd0, 1'b1, 32'h4, 5'd7, 1'b0, 1'b1, 32'h0800_0000},
    '{FuAlu, AluSll, 5'd2, 5'd0, 1'b1, 32'd33, 5'd8, 1'b0, 1'b1, 32'h0000_000A},
    '{FuAlu, AluAnd, 5'd3, 5'd1, 1'b0, 32'h0, 5'd9, 1'b0, 1'b1, 32'h8000_0000},
    '{FuAlu, AluOr, 5'd2, 5'd7, 1'b0, 32'h0, 5'd10, 1'b0, 1'b1, 32'h0800_0005},
    '{FuAlu, AluXor, 5'd3, 5'd0, 1'b1, 32'hFFFF_FFFF, 5'd11, 1'b0, 1'b1, 32'h7FFF_FFFA},
    '{FuAlu, AluAdd, 5'd0, 5'd0, 1'b1, 32'h7, 5'd0, 1'b0, 1'b1, 32'h0000_0007}, // r0 target.
    '{FuAlu, AluOr, 5'd0, 5'd2, 1'b0, 32'h0, 5'd12, 1'b0, 1'b1, 32'h0000_0005},
    '{FuMul, 4'(MulMul), 5'd1, 5'd2, 1'b0, 32'h0, 5'd13, 1'b0, 1'b1, 32'h8000_0000},
    '{FuMul, 4'(MulMulh), 5'd1, 5'd2, 1'b0, 32'h0, 5'd14, 1'b0, 1'b1, 32'hFFFF_FFFD},
    '{FuMul, 4'(MulMulhsu), 5'd1, 5'd11, 1'b0, 32'h0, 5'd15, 1'b0, 1'b1, 32'hC000_0003},
    '{FuMul, 4'(MulMulhu), 5'd1, 5'd6, 1'b0, 32'h0, 5'd16, 1'b0, 1'b1, 32'h7C00_0000},
    '{FuDiv, 4'(DivDiv), 5'd3, 5'd2, 1'b0, 32'h0, 5'd17, 1'b0, 1'b1, 32'hE666_6668},
    '{FuAlu, AluAdd, 5'd2, 5'd0, 1'b1, 32'h1, 5'd18, 1'b0, 1'b1, 32'h0000_0006},
    '{FuMul, 4'(MulMul), 5'd2, 5'd2, 1'b0, 32'h0, 5'd19, 1'b0, 1'b1, 32'h0000_0019},
    '{FuDiv, 4'(DivRem), 5'd3, 5'd2, 1'b0, 32'h0, 5'd20, 1'b0, 1'b1, 32'hFFFF_FFFD},
    '{FuDiv, 4'(DivDivu), 5'd1, 5'd2, 1'b0, 32'h0, 5'd21, 1'b0, 1'b1, 32'h1999_9999},
    '{FuDiv, 4'(DivRemu), 5'd1, 5'd2, 1'b0, 32'h0, 5'd22, 1'b0, 1'b1, 32'h0000_0003},
    '{FuDiv, 4'(DivDiv), 5'd2, 5'd0, 1'b0, 32'h0, 5'd23, 1'b0, 1'b1, 32'hFFFF_FFFF},
    '{FuDiv, 4'(DivRem), 5'd2, 5'd0, 1'b0, 32'h0, 5'd24, 1'b0, 1'b1, 32'h0000_0005},
    '{FuDiv, 4'(DivDiv), 5'd1, 5'd0, 1'b1, 32'hFFFF_FFFF, 5'd25, 1'b0, 1'b1, 32'h8000_0000},
    '{FuDiv, 4'(DivRem), 5'd1, 5'd0, 1'b1, 32'hFFFF_FFFF, 5'd26, 1'b0, 1'b1, 32'h0000_0000},
    '{FuAlu, AluAdd, 5'd0, 5'd0, 1'b1, 32'h1234, 5'd28, 1'b0, 1'b1, 32'h0000_1234},
    '{FuMul, 4'(MulMul), 5'd2, 5'd2, 1'b0, 32'h0, 5'd27, 1'b0, 1'b1, 32'h0000_0019},
    '{FuMul, 4'(MulMul), 5'd2, 5'd2, 1'b0, 32'h0, 5'd28, 1'b0, 1'b1, 32'h0000_0019},
    '{FuMul, 4'(MulMul), 5'd2, 5'd2, 1'b0, 32'h0, 5'd12, 1'b1, 1'b0, 32'h0000_0019},
    '{FuAlu, AluAdd, 5'd12, 5'd0, 1'b1, 32'h0, 5'd30, 1'b0, 1'b1, 32'h0000_0005} // old r12.
};

`default_nettype wire
`endif

// ==== sim/tbExecCluster.sv ====
`default_nettype none

module tbExecCluster;

timeunit 1ns;
timeprecision 1ps;

import ExecPkg::*;

localparam int MulStages = 3;
localparam int ReadyTimeout = 200;
localparam int DrainTimeout = 500;
localparam int NumRandom = 40;

typedef struct packed {
    FuType fu;
    logic [3:0] op;
    RegIdx srcA;
    RegIdx srcB;
    logic useImm;
    Word imm;
    RegIdx dst;
    logic flushAfter; // flush at sqN - 1 right after acceptance.
    logic wbExp;
    Word expResult;
} Row;

logic clk;
logic rst;
IssueUop issue;
Flush flush;
logic ready;
WbOut wb;

logic [31:0] lfsr;
int errors = 0;
int cycle = 0;
int outstanding = 0;
int overlapOps = 0;
logic timedOut = 1'b0;
Word modelRegs[32];
logic expPend[128];
Word expVal[128];
RegIdx expDst[128];
FuType expFu[128];
int acceptAt[128];

ExecCluster #(.MulStages(MulStages)) dut (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .flush(flush),
    .ready(ready),
    .wb(wb)
);

`include "tbVectors.svh"

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

always @(posedge clk) cycle <= cycle + 1;

function automatic logic [31:0] stepLfsr(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] takeBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = stepLfsr(lfsr);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

function automatic Word aluModel(logic [3:0] op, Word a, Word b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (AluOp'(op))
        AluAdd: return a + b;
        AluSub: return a + ~b + 32'd1;
        AluAnd: return a & b;
        AluOr: return a | b;
        AluXor: return a ^ b;
        AluSll: return a << b[4:0];
        AluSrl: return a >> b[4:0];
        AluSra: return ext[31:0];
        AluSlt: return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)}; // biased compare.
        AluSltu: return {31'd0, a < b};
        default: return '0;
    endcase
endfunction

function automatic Word mulModel(logic [1:0] op, Word a, Word b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = (op != MulMulhu) ? {{32{a[31]}}, a} : {32'd0, a};
    xb = (op == MulMul || op == MulMulh) ? {{32{b[31]}}, b} : {32'd0, b};
    p = xa * xb; // low 64 bits are exact for every sign mix.
    return (op == MulMul) ? p[31:0] : p[63:32];
endfunction

function automatic logic divPending();
    for (int i = 0; i < 128; i++) begin
        if (expPend[i] && expFu[i] == FuDiv) return 1'b1;
    end
    return 1'b0;
endfunction

task automatic presentOp(IssueUop u, output logic ok);
    int waited;
    waited = 0;
    @(posedge clk);
    issue <= u;
    flush <= '0;
    @(negedge clk);
    while (!ready && waited < ReadyTimeout) begin
        @(negedge clk);
        waited++;
    end
    ok = ready;
    if (!ok) begin
        errors++;
        timedOut = 1'b1;
        $display("timed out waiting for ready on sqN %0d", u.sqN);
    end
endtask

// called at the negedge before the accepting edge.
task automatic recordAccept(IssueUop u, logic wbExp, Word value);
    if (u.fu == FuDiv) begin
        assert (!divPending()) else begin
            errors++;
            $display("second divide accepted while another was still running");
        end
    end
    else if (divPending()) begin
        overlapOps++; // fast op next to a running divide.
    end
    if (wbExp) begin
        expPend[u.sqN] = 1'b1;
        expVal[u.sqN] = value;
        expDst[u.sqN] = u.dst;
        expFu[u.sqN] = u.fu;
        acceptAt[u.sqN] = cycle + 1;
        outstanding++;
        if (u.dst != '0) modelRegs[u.dst] = value;
    end
endtask

task automatic checkWb();
    int lat;
    lat = cycle + 1 - acceptAt[wb.sqN];
    assert (expPend[wb.sqN]) else begin
        errors++;
        $display("unexpected writeback for sqN %0d", wb.sqN);
    end
    if (expPend[wb.sqN]) begin
        assert (wb.result == expVal[wb.sqN]) else begin
            errors++;
            $display("ERR wb.result sqN %h: got %h expected %h",
                wb.sqN, wb.result, expVal[wb.sqN]);
        end
        assert (wb.dst == expDst[wb.sqN]) else begin
            errors++;
            $display("ERR wb.dst sqN %h: got %h expected %h", wb.sqN, wb.dst, expDst[wb.sqN]);
        end
        if (expFu[wb.sqN] == FuAlu) begin
            assert (lat == 2) else begin
                errors++;
                $display("ERR wb.valid latency sqN %h: got %h expected %h", wb.sqN, lat, 2);
            end
        end
        else if (expFu[wb.sqN] == FuMul) begin
            assert (lat == MulStages + 1) else begin
                errors++;
                $display("ERR wb.valid latency sqN %h: got %h expected %h",
                    wb.sqN, lat, MulStages + 1);
            end
        end
        else begin
            assert (lat >= 34) else begin
                errors++;
                $display("ERR wb.valid latency sqN %h: got %h expected at least %h",
                    wb.sqN, lat, 34);
            end
        end
        expPend[wb.sqN] = 1'b0;
        outstanding--;
    end
endtask

always @(negedge clk) begin
    if (!rst && wb.valid) checkWb();
end

initial begin
    IssueUop u;
    SqN nextSq;
    Word a;
    Word b;
    Word value;
    logic ok;
    int waited;
    issue = '0;
    flush = '0;
    rst = 1'b1;
    lfsr = 32'h8a83;
    nextSq = '0;
    for (int i = 0; i < 128; i++) expPend[i] = 1'b0;
    for (int i = 0; i < 32; i++) modelRegs[i] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < NumRows; i++) begin
        u = '0;
        u.valid = 1'b1;
        u.fu = vectors[i].fu;
        u.op = vectors[i].op;
        u.srcA = vectors[i].srcA;
        u.srcB = vectors[i].srcB;
        u.useImm = vectors[i].useImm;
        u.imm = vectors[i].imm;
        u.dst = vectors[i].dst;
        u.sqN = nextSq;
        nextSq = nextSq + 7'd1;
        presentOp(u, ok);
        if (!ok) break;
        recordAccept(u, vectors[i].wbExp, vectors[i].expResult);
        if (vectors[i].flushAfter) begin
            @(posedge clk);
            issue <= '0; // nothing new may enter under the flush.
            flush <= {1'b1, SqN'(u.sqN - 7'd1)};
        end
    end

    for (int i = 0; i < NumRandom && !timedOut; i++) begin
        u = '0;
        u.valid = 1'b1;
        u.fu = takeBits(1) ? FuMul : FuAlu;
        u.op = (u.fu == FuMul) ? 4'(takeBits(2)) : 4'(takeBits(4) % 10);
        u.srcA = 5'(1 + takeBits(3) % 7);
        u.srcB = 5'(1 + takeBits(3) % 7);
        u.useImm = 1'(takeBits(1));
        u.imm = takeBits(32);
        u.dst = 5'(1 + takeBits(3) % 7);
        u.sqN = nextSq;
        nextSq = nextSq + 7'd1;
        a = modelRegs[u.srcA];
        b = u.useImm ? u.imm : modelRegs[u.srcB];
        value = (u.fu == FuMul) ? mulModel(u.op[1:0], a, b) : aluModel(u.op, a, b);
        presentOp(u, ok);
        if (!ok) break;
        recordAccept(u, 1'b1, value);
    end

    @(posedge clk);
    issue <= '0;
    flush <= '0;
    waited = 0;
    while (!timedOut && outstanding > 0 && waited < DrainTimeout) begin
        @(negedge clk);
        waited++;
    end
    if (outstanding > 0) begin
        errors++;
        $display("%0d expected writebacks never arrived", outstanding);
    end
    assert (overlapOps > 0) else begin
        errors++;
        $display("no ALU or MUL operation was accepted while a divide was running");
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
        $display("SIMULATION PASSED");
    end
    else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+sim
hdl/ExecPkg.sv
hdl/IssueGate.sv
hdl/OperandFetch.sv
hdl/IntAlu.sv
hdl/Multiplier.sv
hdl/Divider.sv
hdl/ExecCluster.sv
sim/tbExecCluster.sv

// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv sim/*.sv sim/*.svh)

.PHONY: all run clean

all: run

obj_dir/VtbExecCluster: $(SRCS) flist.f
	verilator --binary --assert --timing -j 0 --top-module tbExecCluster -f flist.f

run: obj_dir/VtbExecCluster
	./obj_dir/VtbExecCluster | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
